//--- filelist.f
hw/pov_pkg.sv
hw/column_mask.sv
hw/sphere_columns.sv
hw/cube_columns.sv
hw/frame_manager.sv
hw/pov_display_top.sv
verif/pov_display_properties.sv
verif/tb_pov_display.sv

//--- Bender.yml
package:
  name: pov_display

sources:
  # design, package first
  - hw/pov_pkg.sv
  - hw/column_mask.sv
  - hw/sphere_columns.sv
  - hw/cube_columns.sv
  - hw/frame_manager.sv
  - hw/pov_display_top.sv

  # verification, top module tb_pov_display
  - target: test
    files:
      - verif/pov_display_properties.sv
      - verif/tb_pov_display.sv

//--- verif/tb_pov_display.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the pov column feeder at small geometry
module tb_pov_display
    import pov_pkg::*;
();

    localparam int ROTATIONAL_RES = 64;
    localparam int NUM_ROWS       = 16;
    localparam int SCAN_RATE      = 8;
    localparam int ANG_W          = $clog2(ROTATIONAL_RES);
    localparam int COL_W          = $clog2(SCAN_RATE);
    localparam int COLS_W         = 2 * NUM_ROWS * PIXEL_W; // widest compared signal
    localparam int MAX_CYCLES     = 4000; // tests need roughly 2000
    localparam int SEED           = 53932;

    typedef pixel_t [1:0][NUM_ROWS-1:0] pair_t;

    logic             clk_in;
    logic             rst_in;
    pov_mode_e        mode;
    logic [ANG_W-1:0] dtheta;
    logic             hub75_ready;
    pair_t            columns;
    logic [COL_W-1:0] col_num1;
    logic [COL_W:0]   col_num2;
    logic             data_valid;

    // expected state of the registered outputs
    pair_t            exp_cols;
    logic [COL_W-1:0] exp_num1;
    logic [COL_W:0]   exp_num2;
    logic             exp_valid;
    int               model_idx;       // own copy of the scan index
    int               cycle_count;

    pov_display_top #(
        .ROTATIONAL_RES(ROTATIONAL_RES),
        .NUM_ROWS      (NUM_ROWS),
        .SCAN_RATE     (SCAN_RATE)
    ) dut (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .mode       (mode),
        .dtheta     (dtheta),
        .hub75_ready(hub75_ready),
        .columns    (columns),
        .col_num1   (col_num1),
        .col_num2   (col_num2),
        .data_valid (data_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in; // 40 ns period
    end

    task automatic check_value(input string name, input logic [COLS_W-1:0] got,
                               input logic [COLS_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // column c sits at c*RES/(2*SCAN_RATE) and shows in the front half turn
    function automatic bit column_visible(input int col, input int angle);
        int pos;
        int rel;
        pos = (col * ROTATIONAL_RES) / (2 * SCAN_RATE);
        rel = (pos - angle) % ROTATIONAL_RES;
        if (rel < 0) begin
            rel = rel + ROTATIONAL_RES; // bring into 0 .. RES-1
        end
        return rel < ROTATIONAL_RES / 2;
    endfunction

    // expected pair for scan index k
    function automatic pair_t expected_pair(input pov_mode_e m, input int angle, input int k);
        pair_t p;
        int    col;
        int    dc;
        int    dr;
        int    adc;
        int    adr;
        int    hw;
        bit    in_disc;
        bit    on_square;
        p  = '0;
        hw = NUM_ROWS / 4 - angle % 4; // cube half-width
        for (int h = 0; h < 2; h++) begin
            col = k + h * SCAN_RATE;
            dc  = col % SCAN_RATE - SCAN_RATE / 2;
            adc = (dc < 0) ? -dc : dc;
            for (int r = 0; r < NUM_ROWS; r++) begin
                dr        = r - NUM_ROWS / 2;
                adr       = (dr < 0) ? -dr : dr;
                in_disc   = (dc * dc + dr * dr) <= (NUM_ROWS / 4) * (NUM_ROWS / 4);
                on_square = ((adr == hw) && (adc <= hw)) || ((adc == hw) && (adr <= hw));
                if (!column_visible(col, angle)) begin
                    p[h][r] = '0; // back-facing half
                end else if (m == MODE_CYLINDER) begin
                    p[h][r] = CYLINDER_COLOR;
                end else if (m == MODE_SPHERE && in_disc) begin
                    p[h][r] = SPHERE_COLOR;
                end else if (m == MODE_CUBE && on_square) begin
                    p[h][r] = CUBE_COLOR;
                end
            end
        end
        return p;
    endfunction

    // reference model sampled at the rising edge
    always @(posedge clk_in) begin
        if (rst_in) begin
            exp_cols   <= '0;
            exp_num1   <= '0;
            exp_num2   <= '0;
            exp_valid  <= 1'b0;
            model_idx  <= 0;
        end else if (hub75_ready) begin
            exp_cols  <= expected_pair(mode, int'(dtheta), model_idx);
            exp_num1  <= COL_W'(model_idx);
            exp_num2  <= (COL_W + 1)'(model_idx + SCAN_RATE);
            exp_valid <= 1'b1;
            model_idx <= (model_idx == SCAN_RATE - 1) ? 0 : model_idx + 1;
        end else begin
            exp_valid <= 1'b0; // everything else holds
        end
    end

    // compare once the edge has settled
    always @(posedge clk_in) begin
        #1;
        check_value("data_valid", data_valid, exp_valid);
        check_value("col_num1", col_num1, exp_num1);
        check_value("col_num2", col_num2, exp_num2);
        check_value("columns", columns, exp_cols);
        if (dut.u_frame_manager.u_props.fail_count != 0) begin
            $display("a handshake or numbering assertion failed at %0t ns", $time);
            $display("Errors found");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Errors found");
        $fatal(1, "timeout");
    end

    // ready held high for one pair per cycle
    task automatic run_pairs(input pov_mode_e m, input int angle, input int n);
        repeat (n) begin
            @(negedge clk_in);
            mode        = m;
            dtheta      = ANG_W'(angle);
            hub75_ready = 1'b1;
        end
    endtask

    // one ready cycle then a random idle gap while the angle wanders
    task automatic run_gapped(input pov_mode_e m, input int angle, input int n);
        int gap;
        repeat (n) begin
            @(negedge clk_in);
            mode        = m;
            dtheta      = ANG_W'(angle);
            hub75_ready = 1'b1;
            gap         = $urandom_range(1, 5);
            repeat (gap) begin
                @(negedge clk_in);
                hub75_ready = 1'b0;
                dtheta      = ANG_W'($urandom_range(0, ROTATIONAL_RES - 1));
            end
        end
    endtask

    // full cylinder scan lights exactly half of all columns
    task automatic mask_scan(input int angle);
        int lit_halves;
        lit_halves = 0;
        @(negedge clk_in);
        mode        = MODE_CYLINDER;
        dtheta      = ANG_W'(angle);
        hub75_ready = 1'b1;
        repeat (SCAN_RATE) begin
            @(negedge clk_in);
            if (columns[0] != '0) begin
                lit_halves++;
            end
            if (columns[1] != '0) begin
                lit_halves++;
            end
        end
        check_value("visible_halves", lit_halves, SCAN_RATE);
    endtask

    initial begin
        int angle;
        void'($urandom(SEED));
        rst_in      = 1'b1;
        hub75_ready = 1'b0;
        mode        = MODE_CYLINDER;
        dtheta      = '0;
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        // reset state checked twice to see it hold without ready
        repeat (2) begin
            check_value("data_valid", data_valid, 1'b0);
            check_value("columns", columns, '0);
            check_value("col_num1", col_num1, '0);
            check_value("col_num2", col_num2, '0);
            @(negedge clk_in);
        end

        // every mode, random angles, two scans each
        for (int m = 0; m < 4; m++) begin
            for (int i = 0; i < 8; i++) begin
                angle = $urandom_range(0, ROTATIONAL_RES - 1);
                run_pairs(pov_mode_e'(m), angle, 2 * SCAN_RATE);
            end
        end

        // mask at fixed quarter turns, then random
        mask_scan(0);
        mask_scan(ROTATIONAL_RES / 4);
        mask_scan(ROTATIONAL_RES / 2);
        repeat (5) mask_scan($urandom_range(0, ROTATIONAL_RES - 1));

        // cube outline over four consecutive angles
        for (int a = 8; a < 12; a++) begin
            run_pairs(MODE_CUBE, a, 2 * SCAN_RATE);
        end

        // ready with idle gaps
        for (int m = 0; m < 4; m++) begin
            angle = $urandom_range(0, ROTATIONAL_RES - 1);
            run_gapped(pov_mode_e'(m), angle, 60);
        end

        // switches inside a scan
        run_pairs(MODE_SPHERE, 5, 3);
        run_pairs(MODE_CUBE, 5, 2);
        run_pairs(MODE_CUBE, 40, 2);
        run_pairs(MODE_BLANK, 40, 1);
        run_pairs(MODE_CYLINDER, 17, 4);
        run_pairs(MODE_SPHERE, 50, 3);

        repeat (3) begin
            @(negedge clk_in);
            hub75_ready = 1'b0;
        end
        if (dut.u_frame_manager.u_props.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "assertion failures at end of run");
        end
    end

endmodule

`default_nettype wire

//--- verif/pov_display_properties.sv
`timescale 1ns/1ps
`default_nettype none

// handshake and column numbering checks on the frame manager
module pov_display_properties
    import pov_pkg::*;
#(
    parameter int NUM_ROWS  = 64,
    parameter int SCAN_RATE = 32
) (
    input wire                              clk_in,
    input wire                              rst_in,
    input wire                              hub75_ready,
    input wire pixel_t [1:0][NUM_ROWS-1:0]  columns,
    input wire [$clog2(SCAN_RATE)-1:0]      col_num1,
    input wire [$clog2(SCAN_RATE):0]        col_num2,
    input wire                              data_valid
);

    int fail_count = 0; // polled by the testbench

    // valid only right after a request
    a_valid_after_ready: assert property (@(posedge clk_in) disable iff (rst_in)
        data_valid |-> $past(hub75_ready))
    else begin
        $error("data_valid high without a ready cycle before it");
        fail_count = fail_count + 1;
    end

    a_pair_numbering: assert property (@(posedge clk_in) disable iff (rst_in)
        data_valid |-> (col_num2 == col_num1 + SCAN_RATE))
    else begin
        $error("col_num2 is not col_num1 plus SCAN_RATE");
        fail_count = fail_count + 1;
    end

    // idle driver, nothing moves
    a_hold_when_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        !hub75_ready |=> !data_valid && $stable(columns) && $stable(col_num1)
                         && $stable(col_num2))
    else begin
        $error("outputs changed while hub75_ready was low");
        fail_count = fail_count + 1;
    end

    a_reset_clears_valid: assert property (@(posedge clk_in) rst_in |=> !data_valid)
    else begin
        $error("data_valid high after reset");
        fail_count = fail_count + 1;
    end

endmodule

bind frame_manager pov_display_properties #(
    .NUM_ROWS (NUM_ROWS),
    .SCAN_RATE(SCAN_RATE)
) u_props (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .hub75_ready(hub75_ready),
    .columns    (columns),
    .col_num1   (col_num1),
    .col_num2   (col_num2),
    .data_valid (data_valid)
);

`default_nettype wire

//--- hw/pov_display_top.sv
`timescale 1ns/1ps
`default_nettype none

// pov column feeder, top level
// sets the geometry, all timing lives in the frame manager
module pov_display_top
    import pov_pkg::*;
#(
    parameter int ROTATIONAL_RES = 256, // angle steps per turn
    parameter int NUM_ROWS       = 64,  // leds per column
    parameter int SCAN_RATE      = 32   // column pairs per scan
) (
    input  wire                                 clk_in,
    input  wire                                 rst_in,
    input  wire    pov_mode_e                   mode,
    input  wire    [$clog2(ROTATIONAL_RES)-1:0] dtheta,
    input  wire                                 hub75_ready,
    output pixel_t [1:0][NUM_ROWS-1:0]          columns,    // [0] = col_num1, [1] = col_num2
    output logic   [$clog2(SCAN_RATE)-1:0]      col_num1,
    output logic   [$clog2(SCAN_RATE):0]        col_num2,
    output logic                                data_valid
);

    pixel_t [1:0][NUM_ROWS-1:0]     fm_columns;
    logic   [$clog2(SCAN_RATE)-1:0] fm_col_num1;
    logic   [$clog2(SCAN_RATE):0]   fm_col_num2;
    logic                           fm_data_valid;

    frame_manager #(
        .ROTATIONAL_RES(ROTATIONAL_RES),
        .NUM_ROWS      (NUM_ROWS),
        .SCAN_RATE     (SCAN_RATE)
    ) u_frame_manager (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .mode       (mode),
        .dtheta     (dtheta),
        .hub75_ready(hub75_ready),
        .columns    (fm_columns),
        .col_num1   (fm_col_num1),
        .col_num2   (fm_col_num2),
        .data_valid (fm_data_valid)
    );

    assign columns    = fm_columns;
    assign col_num1   = fm_col_num1;
    assign col_num2   = fm_col_num2;
    assign data_valid = fm_data_valid;

endmodule

`default_nettype wire

//--- hw/frame_manager.sv
`timescale 1ns/1ps
`default_nettype none

// walks the column pairs, picks the pattern for the mode,
// masks hidden columns and registers one pair per ready cycle
module frame_manager
    import pov_pkg::*;
#(
    parameter int ROTATIONAL_RES = 256,
    parameter int NUM_ROWS       = 64,
    parameter int SCAN_RATE      = 32
) (
    input  wire                                 clk_in,
    input  wire                                 rst_in,
    input  wire    pov_mode_e                   mode,
    input  wire    [$clog2(ROTATIONAL_RES)-1:0] dtheta,      // angle from the tracker
    input  wire                                 hub75_ready, // driver wants a pair
    output pixel_t [1:0][NUM_ROWS-1:0]          columns,
    output logic   [$clog2(SCAN_RATE)-1:0]      col_num1,
    output logic   [$clog2(SCAN_RATE):0]        col_num2,
    output logic                                data_valid
);

    localparam int COL_W    = $clog2(SCAN_RATE);
    localparam int IDX_W    = COL_W + 1; // spans both halves of the panel
    localparam int NUM_COLS = 2 * SCAN_RATE;

    logic [COL_W-1:0]    col_index;     // scan position, 0 .. SCAN_RATE-1
    logic [IDX_W-1:0]    column_index1; // left column of the pair
    logic [IDX_W-1:0]    column_index2; // partner, SCAN_RATE further
    logic [NUM_COLS-1:0] col_indices;   // visibility per column

    pixel_t [1:0][NUM_ROWS-1:0] sphere_cols;
    pixel_t [1:0][NUM_ROWS-1:0] cube_cols;
    pixel_t [1:0][NUM_ROWS-1:0] cyl_cols;
    pixel_t [1:0][NUM_ROWS-1:0] sel_cols;    // pair for current mode
    pixel_t [1:0][NUM_ROWS-1:0] masked_cols; // after hiding back-facing halves

    assign column_index1 = {1'b0, col_index};
    assign column_index2 = column_index1 + IDX_W'(SCAN_RATE);

    column_mask #(
        .ROTATIONAL_RES(ROTATIONAL_RES),
        .SCAN_RATE     (SCAN_RATE)
    ) u_mask (
        .dtheta     (dtheta),
        .col_indices(col_indices)
    );

    sphere_columns #(
        .NUM_ROWS (NUM_ROWS),
        .SCAN_RATE(SCAN_RATE)
    ) u_sphere (
        .column_index1(column_index1),
        .column_index2(column_index2),
        .columns      (sphere_cols)
    );

    cube_columns #(
        .ROTATIONAL_RES(ROTATIONAL_RES),
        .NUM_ROWS      (NUM_ROWS),
        .SCAN_RATE     (SCAN_RATE)
    ) u_cube (
        .dtheta       (dtheta),
        .column_index1(column_index1),
        .column_index2(column_index2),
        .columns      (cube_cols)
    );

    // cylinder is just solid colour
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                cyl_cols[h][r] = CYLINDER_COLOR;
            end
        end
    end

    always_comb begin
        case (mode)
            MODE_CYLINDER: sel_cols = cyl_cols;
            MODE_SPHERE:   sel_cols = sphere_cols;
            MODE_CUBE:     sel_cols = cube_cols;
            default:       sel_cols = '0; // blank mode
        endcase
        // each half blanked by its own mask bit, never left stale
        masked_cols[0] = col_indices[column_index1] ? sel_cols[0] : '0;
        masked_cols[1] = col_indices[column_index2] ? sel_cols[1] : '0;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            col_index  <= '0;
            columns    <= '0;
            col_num1   <= '0;
            col_num2   <= '0;
            data_valid <= 1'b0;
        end else if (hub75_ready) begin
            columns    <= masked_cols;
            col_num1   <= col_index;
            col_num2   <= column_index2;
            data_valid <= 1'b1; // one cycle after the request
            if (col_index == COL_W'(SCAN_RATE - 1)) begin
                col_index <= '0; // wrap at last pair
            end else begin
                col_index <= col_index + 1'b1;
            end
        end else begin
            data_valid <= 1'b0; // outputs and index hold
        end
    end

endmodule

`default_nettype wire

//--- hw/cube_columns.sv
`timescale 1ns/1ps
`default_nettype none

// square outline for one column pair
// half-width shrinks with the low two angle bits
module cube_columns
    import pov_pkg::*;
#(
    parameter int ROTATIONAL_RES = 256,
    parameter int NUM_ROWS       = 64,
    parameter int SCAN_RATE      = 32
) (
    input  wire    [$clog2(ROTATIONAL_RES)-1:0] dtheta,
    input  wire    [$clog2(SCAN_RATE):0]        column_index1, // k
    input  wire    [$clog2(SCAN_RATE):0]        column_index2, // k + SCAN_RATE
    output pixel_t [1:0][NUM_ROWS-1:0]          columns
);

    int half_w; // outline half-width for this angle

    // nominal size minus angle mod 4
    assign half_w = (NUM_ROWS / 4) - int'(dtheta % 4);

    function automatic int abs_int(input int v);
        begin
            return (v < 0) ? -v : v;
        end
    endfunction

    // pixel sits on one of the four edges of the square
    function automatic logic on_outline(input int col, input int row, input int hw);
        int dc;
        int dr;
        logic on_row_edge;
        logic on_col_edge;
        begin
            dc = abs_int((col % SCAN_RATE) - (SCAN_RATE / 2));
            dr = abs_int(row - (NUM_ROWS / 2));
            on_row_edge = (dr == hw) && (dc <= hw); // top / bottom edge
            on_col_edge = (dc == hw) && (dr <= hw); // left / right edge
            return on_row_edge || on_col_edge;
        end
    endfunction

    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (on_outline(int'(column_index1), r, half_w)) begin
                columns[0][r] = CUBE_COLOR;
            end else begin
                columns[0][r] = '0;
            end
            if (on_outline(int'(column_index2), r, half_w)) begin
                columns[1][r] = CUBE_COLOR;
            end else begin
                columns[1][r] = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/sphere_columns.sv
`timescale 1ns/1ps
`default_nettype none

// disc pattern for one column pair
// same picture at every angle, so no dtheta here
module sphere_columns
    import pov_pkg::*;
#(
    parameter int NUM_ROWS  = 64,
    parameter int SCAN_RATE = 32
) (
    input  wire    [$clog2(SCAN_RATE):0]  column_index1, // k
    input  wire    [$clog2(SCAN_RATE):0]  column_index2, // k + SCAN_RATE
    output pixel_t [1:0][NUM_ROWS-1:0]    columns
);

    localparam int RADIUS    = NUM_ROWS / 4;
    localparam int RADIUS_SQ = RADIUS * RADIUS;

    // true when (row, col) lies inside the disc
    function automatic logic in_disc(input int col, input int row);
        int col_off;
        int row_off;
        int dist_sq;
        begin
            col_off = (col % SCAN_RATE) - (SCAN_RATE / 2); // both halves share the disc
            row_off = row - (NUM_ROWS / 2);
            dist_sq = col_off * col_off + row_off * row_off;
            return (dist_sq <= RADIUS_SQ);
        end
    endfunction

    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            // first column of the pair
            if (in_disc(int'(column_index1), r)) begin
                columns[0][r] = SPHERE_COLOR;
            end else begin
                columns[0][r] = '0;
            end
            // second column, SCAN_RATE further on
            if (in_disc(int'(column_index2), r)) begin
                columns[1][r] = SPHERE_COLOR;
            end else begin
                columns[1][r] = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/column_mask.sv
`timescale 1ns/1ps
`default_nettype none

// marks which columns currently face the viewer
// pure comb, every column evaluated in parallel
module column_mask #(
    parameter int ROTATIONAL_RES = 256, // angle steps per turn, power of two
    parameter int SCAN_RATE      = 32   // column pairs
) (
    input  wire  [$clog2(ROTATIONAL_RES)-1:0] dtheta,      // current rotation angle
    output logic [2*SCAN_RATE-1:0]            col_indices  // 1 = column visible
);

    localparam int NUM_COLS = 2 * SCAN_RATE;
    localparam int ANG_W    = $clog2(ROTATIONAL_RES);
    localparam int HALF_REV = ROTATIONAL_RES / 2;

    for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
        // fixed angular slot of this column on the panel
        localparam int POS = ((c * ROTATIONAL_RES) / NUM_COLS) % ROTATIONAL_RES;

        logic [ANG_W-1:0] rel_angle; // position relative to viewer

        // truncation to ANG_W bits does the modulo wrap
        assign rel_angle = ANG_W'(POS) - dtheta;

        // front half of the revolution only
        assign col_indices[c] = (rel_angle < ANG_W'(HALF_REV));
    end

endmodule

`default_nettype wire

//--- hw/pov_pkg.sv
`default_nettype none

package pov_pkg;

    // 3 bits each of red, green, blue
    localparam int PIXEL_W = 9;

    typedef logic [PIXEL_W-1:0] pixel_t; // {r[2:0], g[2:0], b[2:0]}

    // display patterns, picked by the mode input
    typedef enum logic [1:0] {
        MODE_CYLINDER = 2'd0, // every visible pixel lit
        MODE_SPHERE   = 2'd1, // disc, angle independent
        MODE_CUBE     = 2'd2, // square outline, size follows angle
        MODE_BLANK    = 2'd3  // all off
    } pov_mode_e;

    // one fixed colour per pattern, all non-zero
    localparam pixel_t CYLINDER_COLOR = 9'b111_111_111; // white
    localparam pixel_t SPHERE_COLOR   = 9'b000_011_111; // cyan-ish blue
    localparam pixel_t CUBE_COLOR     = 9'b111_100_000; // orange

endpackage

`default_nettype wire
